//--- flist.f
+incdir+common
common/knightPkg.sv
uart/uartRx.sv
uart/uartTx.sv
hdl/frameAssembler.sv
hdl/creditQueue.sv
hdl/commandSequencer.sv
motor/motorDrive.sv
hdl/knightTop.sv
tests/uartBfm.sv
tests/knightTop_tb.sv

//--- Makefile
# Verilator flow for the knight drive-control core

TB_TOP = knightTop_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f flist.f --top-module knightTop

# The run passes only if the pass line shows up in the output
sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TB_TOP) -o simv
	@out="$$(./obj_dir/simv)"; echo "$$out"; echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

//--- tests/knightTop_tb.sv
`timescale 1ns/1ps
`include "knight_config.svh"

module knightTop_tb;

  localparam int NumTests   = 13;
  localparam int MaxCmds    = 8;
  localparam int BurstStops = 6;
  // A command is two UART bytes of ten bits each and a response is one byte
  localparam int FrameCycles = 20 * `KNIGHT_BAUD_DIV;
  localparam int ByteCycles  = 10 * `KNIGHT_BAUD_DIV;
  // Time for a full ramp over the whole level range
  localparam int RampCycles  = 64 * `KNIGHT_RAMP_DIV;
  localparam int ByteWait    = RampCycles + 4 * FrameCycles;
  localparam logic [7:0] AckByte = 8'hA5;
  localparam logic [7:0] NakByte = 8'hE0;

  logic clk;
  logic rst;
  logic rx;
  logic tx;
  logic lftPwm;
  logic rghtPwm;

  // Stimulus table with one row per test
  string               nameTab  [NumTests];
  knightPkg::cmdWord_t cmdTab   [NumTests][MaxCmds];
  int                  nCmdTab  [NumTests];
  logic [7:0]          respTab  [NumTests];
  int                  nRespTab [NumTests];
  logic [5:0]          lftTab   [NumTests];
  logic [5:0]          rghtTab  [NumTests];

  int seed;
  int errors;
  int passCount;
  int failCount;
  int cycleCount;
  int cycleLimit;

  knightTop u_dut (.clk(clk), .rst(rst), .rx(rx), .tx(tx), .lftPwm(lftPwm), .rghtPwm(rghtPwm));

  uartBfm hostUart (.clk(clk), .rx(rx), .tx(tx));

  initial begin
    clk = 1'b0;
  end

  always #4 clk = ~clk;

  // Backstop for a run that stops making progress
  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
      $display("run stopped by the cycle limit of %0d", cycleLimit);
      $display("tests failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Table construction
  ////////////////////////////////////////////////////////////

  // DRIVE carries the left level in bits 11..6 and the right in 5..0
  function automatic knightPkg::cmdWord_t driveWord(input logic [5:0] lft, input logic [5:0] rght);
    return {4'd4, lft, rght};
  endfunction

  function automatic knightPkg::cmdWord_t stopWord();
    return {4'd2, 12'h000};
  endfunction

  task automatic addCmd(input int t, input knightPkg::cmdWord_t word);
    cmdTab[t][nCmdTab[t]] = word;
    nCmdTab[t]++;
  endtask

  task automatic setRow(input int t, input string name, input int nResp,
                        input logic [7:0] resp, input logic [5:0] lft, input logic [5:0] rght);
    nameTab[t]  = name;
    nRespTab[t] = nResp;
    respTab[t]  = resp;
    lftTab[t]   = lft;
    rghtTab[t]  = rght;
  endtask

  task automatic buildTable();
    logic [5:0] l;
    logic [5:0] r;
    int accepted;
    for (int t = 0; t < NumTests; t++) begin
      nCmdTab[t] = 0;
    end
    setRow(0, "reset idle", 0, AckByte, 6'd0, 6'd0);
    addCmd(1, driveWord(6'd40, 6'd12));
    setRow(1, "fixed drive", 1, AckByte, 6'd40, 6'd12);
    for (int t = 2; t <= 6; t++) begin
      l = 6'($random(seed));
      r = 6'($random(seed));
      addCmd(t, driveWord(l, r));
      setRow(t, "random drive", 1, AckByte, l, r);
    end
    // Unknown opcodes get a NAK and keep the levels of the last drive
    addCmd(7, {4'd0, 12'h5A3});
    addCmd(8, {4'd7, 12'hFFF});
    addCmd(9, {4'd15, 12'h000});
    for (int t = 7; t <= 9; t++) begin
      setRow(t, "bad opcode", 1, NakByte, lftTab[6], rghtTab[6]);
    end
    addCmd(10, stopWord());
    setRow(10, "stop", 1, AckByte, 6'd0, 6'd0);
    // The drive is popped at once and frees its credit
    // The stops then land while it ramps, and only a queue's worth is kept
    addCmd(11, driveWord(6'd63, 6'd63));
    for (int b = 0; b < BurstStops; b++) begin
      addCmd(11, stopWord());
    end
    accepted = (BurstStops > `KNIGHT_QUEUE_DEPTH) ? `KNIGHT_QUEUE_DEPTH : BurstStops;
    setRow(11, "credit burst", 1 + accepted, AckByte, 6'd0, 6'd0);
    l = 6'($random(seed));
    r = 6'($random(seed));
    addCmd(12, driveWord(l, r));
    setRow(12, "drive after burst", 1, AckByte, l, r);
    // Twice the sum of frame time and a full ramp over all tests
    cycleLimit = 0;
    for (int t = 0; t < NumTests; t++) begin
      cycleLimit += nCmdTab[t] * FrameCycles + nRespTab[t] * ByteCycles + RampCycles;
    end
    cycleLimit = 2 * cycleLimit;
  endtask

  ////////////////////////////////////////////////////////////
  // Test steps
  ////////////////////////////////////////////////////////////

  // Line and motor outputs sit idle for the whole window after reset
  task automatic checkIdle();
    int bad;
    bad = 0;
    repeat (200) begin
      @(negedge clk);
      if (bad == 0) begin
        assert (tx === 1'b1) else begin
          $display("FAILED tx expected 0x1 actual 0x%h", tx);
          bad++;
        end
        assert (lftPwm === 1'b0 && rghtPwm === 1'b0) else begin
          $display("FAILED lftPwm/rghtPwm expected 0x0/0x0 actual 0x%h/0x%h", lftPwm, rghtPwm);
          bad++;
        end
      end
    end
    errors += bad;
  endtask

  task automatic waitByte(input int limit, output logic got);
    int n;
    n = 0;
    while (hostUart.pending() == 0 && n < limit) begin
      @(negedge clk);
      n++;
    end
    got = (hostUart.pending() != 0);
  endtask

  // High cycles of each PWM over one full counter period
  task automatic measureDuty(output int lftHigh, output int rghtHigh);
    lftHigh  = 0;
    rghtHigh = 0;
    repeat (64) begin
      @(negedge clk);
      if (lftPwm) lftHigh++;
      if (rghtPwm) rghtHigh++;
    end
  endtask

  task automatic runTest(input int t);
    int errorsBefore;
    int lftHigh;
    int rghtHigh;
    logic got;
    logic [7:0] data;
    errorsBefore = errors;
    if (nCmdTab[t] == 0) begin
      checkIdle();
    end
    for (int c = 0; c < nCmdTab[t]; c++) begin
      hostUart.sendWord(cmdTab[t][c]);
    end
    for (int k = 0; k < nRespTab[t]; k++) begin
      waitByte(ByteWait, got);
      assert (got) else begin
        $display("test %0d: response %0d of %0d never arrived", t, k + 1, nRespTab[t]);
        errors++;
      end
      if (got) begin
        data = hostUart.takeByte();
        assert (data == respTab[t]) else begin
          $display("FAILED tx byte expected 0x%02h actual 0x%02h", respTab[t], data);
          errors++;
        end
      end
    end
    // Nothing more may show up within two frame times
    repeat (2 * FrameCycles) @(negedge clk);
    assert (hostUart.pending() == 0) else begin
      $display("test %0d: %0d unexpected response bytes arrived", t, hostUart.pending());
      errors++;
    end
    while (hostUart.pending() != 0) begin
      void'(hostUart.takeByte());
    end
    assert (hostUart.badFrames == 0) else begin
      $display("test %0d: a response frame had a low stop bit", t);
      errors++;
    end
    measureDuty(lftHigh, rghtHigh);
    assert (lftHigh == int'(lftTab[t])) else begin
      $display("FAILED lftPwm duty expected 0x%02h actual 0x%02h", lftTab[t], 8'(lftHigh));
      errors++;
    end
    assert (rghtHigh == int'(rghtTab[t])) else begin
      $display("FAILED rghtPwm duty expected 0x%02h actual 0x%02h", rghtTab[t], 8'(rghtHigh));
      errors++;
    end
    if (errors == errorsBefore) begin
      passCount++;
      $display("test %0d %s: pass", t, nameTab[t]);
    end else begin
      failCount++;
      $display("test %0d %s: %0d errors", t, nameTab[t], errors - errorsBefore);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    seed       = 32'he255;
    errors     = 0;
    passCount  = 0;
    failCount  = 0;
    cycleCount = 0;
    rst        = 1'b1;
    buildTable();
    repeat (16) @(negedge clk);
    rst = 1'b0;
    for (int t = 0; t < NumTests; t++) begin
      runTest(t);
    end
    $display("%0d tests passed, %0d tests with errors", passCount, failCount);
    if (failCount == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- tests/uartBfm.sv
`timescale 1ns/1ps
`include "knight_config.svh"

// Host side of the UART link
// It sends command words on rx and collects the response bytes seen on tx
module uartBfm (
  input  logic clk,
  output logic rx,
  input  logic tx
);

  // Response bytes in arrival order, the testbench takes them from the front
  logic [7:0] rxBytes [$];

  // Frames whose stop bit read low
  int badFrames;

  initial begin
    rx        = 1'b1;
    badFrames = 0;
  end

  // One 8N1 frame, LSB first, each bit held for a full baud period
  task automatic sendByte(input logic [7:0] data);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};
    for (int b = 0; b < 10; b++) begin
      @(negedge clk);
      rx = frame[b];
      repeat (`KNIGHT_BAUD_DIV - 1) @(negedge clk);
    end
  endtask

  // A command word goes out high byte first
  task automatic sendWord(input knightPkg::cmdWord_t word);
    sendByte(word[15:8]);
    sendByte(word[7:0]);
  endtask

  function automatic int pending();
    return rxBytes.size();
  endfunction

  function automatic logic [7:0] takeByte();
    return rxBytes.pop_front();
  endfunction

  ////////////////////////////////////////////////////////////
  // Response capture
  ////////////////////////////////////////////////////////////

  // tx changes on the rising edge, so it is read on the falling one
  initial begin : capture
    logic [7:0] data;
    forever begin
      @(negedge clk);
      if (tx === 1'b0) begin
        // Step to the middle of the start bit, then a full bit at a time
        repeat (`KNIGHT_BAUD_DIV / 2) @(negedge clk);
        for (int b = 0; b < 8; b++) begin
          repeat (`KNIGHT_BAUD_DIV) @(negedge clk);
          data[b] = tx;
        end
        repeat (`KNIGHT_BAUD_DIV) @(negedge clk);
        if (tx === 1'b1) begin
          rxBytes.push_back(data);
        end else begin
          badFrames++;
        end
      end
    end
  end

endmodule

//--- hdl/knightTop.sv
`timescale 1ns/1ps
`include "knight_config.svh"

// Top of the drive-control core, UART in and out plus the motor PWM outputs
module knightTop (
  input  logic clk,
  input  logic rst,
  input  logic rx,
  output logic tx,
  output logic lftPwm,
  output logic rghtPwm
);

  // Received bytes and assembled commands
  logic                byteValid;
  logic [7:0]          byteData;
  logic                cmdPush;
  knightPkg::cmdWord_t cmdWord;
  logic                cmdValid;
  knightPkg::cmdWord_t cmdHead;
  logic                cmdPop;

  // Responses on their way to the transmitter
  logic                 respPush;
  knightPkg::respByte_t respByte;
  logic                 respValid;
  knightPkg::respByte_t respHead;
  logic                 respPop;
  logic                 respCreditReturn;

  // Motor channels
  knightPkg::level_t             targetLevel [`KNIGHT_NUM_MOTORS];
  logic [`KNIGHT_NUM_MOTORS-1:0] atTarget;
  logic [`KNIGHT_NUM_MOTORS-1:0] pwm;

  ////////////////////////////////////////////////////////////
  // Command path
  ////////////////////////////////////////////////////////////

  uartRx iUartRx (.clk(clk), .rst(rst), .rx(rx), .byteValid(byteValid), .byteData(byteData));

  // Every pop of the command queue is a credit back to the assembler
  frameAssembler iFrameAsm (.clk(clk), .rst(rst), .byteValid(byteValid),
                            .byteData(byteData), .cmdCreditReturn(cmdPop),
                            .cmdPush(cmdPush), .cmdWord(cmdWord));

  creditQueue #(.payload_t(knightPkg::cmdWord_t)) iCmdQueue (
    .clk(clk), .rst(rst), .push(cmdPush), .pushData(cmdWord),
    .pop(cmdPop), .valid(cmdValid), .head(cmdHead));

  commandSequencer iSeq (.clk(clk), .rst(rst), .cmdValid(cmdValid), .cmdHead(cmdHead),
                         .atTarget(atTarget), .respCreditReturn(respCreditReturn),
                         .cmdPop(cmdPop), .targetLevel(targetLevel),
                         .respPush(respPush), .respByte(respByte));

  // Identical channels, index 0 is the left motor
  for (genvar i = 0; i < `KNIGHT_NUM_MOTORS; i++) begin : gMotor
    motorDrive iMotor (.clk(clk), .rst(rst), .targetLevel(targetLevel[i]),
                       .atTarget(atTarget[i]), .pwm(pwm[i]));
  end

  ////////////////////////////////////////////////////////////
  // Response path
  ////////////////////////////////////////////////////////////

  creditQueue #(.payload_t(knightPkg::respByte_t)) iRespQueue (
    .clk(clk), .rst(rst), .push(respPush), .pushData(respByte),
    .pop(respPop), .valid(respValid), .head(respHead));

  uartTx iUartTx (.clk(clk), .rst(rst), .respValid(respValid), .respHead(respHead),
                  .respPop(respPop), .respCreditReturn(respCreditReturn), .tx(tx));

  assign lftPwm  = pwm[0];
  assign rghtPwm = pwm[1];

endmodule

//--- motor/motorDrive.sv
`timescale 1ns/1ps
`include "knight_config.svh"

// One motor channel with a level ramp and a PWM generator
module motorDrive (
  input  logic              clk,
  input  logic              rst,
  input  knightPkg::level_t targetLevel,
  output logic              atTarget,
  output logic              pwm
);

  localparam logic [15:0] RampLast = 16'(`KNIGHT_RAMP_DIV - 1);

  logic [15:0]       rampCnt;
  knightPkg::level_t level;
  logic [5:0]        pwmCnt;

  ////////////////////////////////////////////////////////////
  // Level ramp
  ////////////////////////////////////////////////////////////

  // The level moves by one step per ramp period, so a big jump
  // in the target never reaches the motor all at once
  always_ff @(posedge clk) begin
    if (rst) begin
      rampCnt <= '0;
      level   <= '0;
    end else begin
      if (rampCnt == RampLast) begin
        rampCnt <= '0;
        if (level < targetLevel) begin
          level <= level + 6'd1;
        end else if (level > targetLevel) begin
          level <= level - 6'd1;
        end
      end else begin
        rampCnt <= rampCnt + 16'd1;
      end
    end
  end

  // High once the ramp has caught up with the target
  assign atTarget = (level == targetLevel);

  ////////////////////////////////////////////////////////////
  // PWM
  ////////////////////////////////////////////////////////////

  // The counter wraps every 64 cycles, so the high time per period equals the level
  always_ff @(posedge clk) begin
    if (rst) begin
      pwmCnt <= '0;
      pwm    <= 1'b0;
    end else begin
      pwmCnt <= pwmCnt + 6'd1;
      pwm    <= (pwmCnt < level);
    end
  end

endmodule

//--- hdl/commandSequencer.sv
`timescale 1ns/1ps
`include "knight_config.svh"

// Decodes host commands, steers the motor targets and answers each command
module commandSequencer (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      cmdValid,
  input  knightPkg::cmdWord_t       cmdHead,
  input  logic [`KNIGHT_NUM_MOTORS-1:0] atTarget,
  input  logic                      respCreditReturn,
  output logic                      cmdPop,
  output knightPkg::level_t         targetLevel [`KNIGHT_NUM_MOTORS],
  output logic                      respPush,
  output knightPkg::respByte_t      respByte
);

  localparam int CreditW = $clog2(`KNIGHT_QUEUE_DEPTH + 1);

  typedef enum logic [1:0] {IDLE, SETTLE, RESPOND} seqState_t;

  seqState_t          state;
  knightPkg::opcode_t opcode;
  logic               isMove;
  logic               allSettled;
  logic               haveCredit;
  logic               pushNow;
  logic [CreditW-1:0] credits;

  ////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////

  assign opcode     = knightPkg::opcode_t'(cmdHead[15:12]);
  assign isMove     = (opcode == knightPkg::DRIVE) || (opcode == knightPkg::STOP);
  assign allSettled = &atTarget;
  assign haveCredit = (credits != '0);

  // Only one command is in flight, the next is popped once the answer is out
  assign cmdPop = (state == IDLE) && cmdValid;

  // The answer goes out as soon as it is known and a credit is free
  assign pushNow = haveCredit &&
                   ((state == SETTLE && allSettled) || state == RESPOND);

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= IDLE;
      respPush <= 1'b0;
      credits  <= CreditW'(`KNIGHT_QUEUE_DEPTH);
      for (int i = 0; i < `KNIGHT_NUM_MOTORS; i++) begin
        targetLevel[i] <= '0;
      end
    end else begin
      respPush <= pushNow;
      credits  <= credits + CreditW'(respCreditReturn) - CreditW'(pushNow);
      case (state)
        IDLE: begin
          if (cmdPop) begin
            state <= isMove ? SETTLE : RESPOND;
            // DRIVE packs the left level above the right one, STOP zeroes both
            for (int i = 0; i < `KNIGHT_NUM_MOTORS; i++) begin
              if (opcode == knightPkg::DRIVE) begin
                targetLevel[i] <= cmdHead[11 - 6 * i -: 6];
              end else if (opcode == knightPkg::STOP) begin
                targetLevel[i] <= '0;
              end
            end
          end
        end
        // Out of credits means the answer waits in RESPOND
        SETTLE: begin
          if (allSettled) begin
            state <= haveCredit ? IDLE : RESPOND;
          end
        end
        RESPOND: begin
          if (haveCredit) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // The answer byte is picked once and held until it is pushed
  always_ff @(posedge clk) begin
    if (cmdPop && !isMove) begin
      respByte <= knightPkg::RESP_NAK;
    end else if (state == SETTLE && allSettled) begin
      respByte <= knightPkg::RESP_ACK;
    end
  end

endmodule

//--- hdl/creditQueue.sv
`timescale 1ns/1ps
`include "knight_config.svh"

// FIFO for any payload type, filled by a producer that counts credits
module creditQueue #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     push,
  input  payload_t pushData,
  input  logic     pop,
  output logic     valid,
  output payload_t head
);

  localparam int PtrW = $clog2(`KNIGHT_QUEUE_DEPTH);

  // Pointers carry one extra bit so a full queue differs from an empty one
  logic [PtrW:0] wrPtr;
  logic [PtrW:0] rdPtr;

  payload_t mem [`KNIGHT_QUEUE_DEPTH];

  ////////////////////////////////////////////////////////////
  // Pointers
  ////////////////////////////////////////////////////////////

  // The producer never pushes without a credit
  // so there is no full flag to look at here
  always_ff @(posedge clk) begin
    if (rst) begin
      wrPtr <= '0;
      rdPtr <= '0;
    end else begin
      if (push) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (pop && valid) begin
        rdPtr <= rdPtr + 1'b1;
      end
    end
  end

  // Storage, written at the tail
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wrPtr[PtrW-1:0]] <= pushData;
    end
  end

  // A word written in one cycle shows at the head in the next
  assign valid = (wrPtr != rdPtr);
  assign head  = mem[rdPtr[PtrW-1:0]];

endmodule

//--- hdl/frameAssembler.sv
`timescale 1ns/1ps
`include "knight_config.svh"

// Builds command words from received byte pairs and pushes them under credit
module frameAssembler (
  input  logic               clk,
  input  logic               rst,
  input  logic               byteValid,
  input  logic [7:0]         byteData,
  input  logic               cmdCreditReturn,
  output logic               cmdPush,
  output knightPkg::cmdWord_t cmdWord
);

  localparam int CreditW = $clog2(`KNIGHT_QUEUE_DEPTH + 1);

  logic               haveHigh;
  logic [7:0]         highByte;
  logic [CreditW-1:0] credits;
  logic               spend;

  // A credit is spent only when a whole word is ready and one is left
  // Without a credit the word is dropped, the serial line cannot be stalled
  assign spend = byteValid && haveHigh && (credits != '0);

  ////////////////////////////////////////////////////////////
  // Byte phase and credit count
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      haveHigh <= 1'b0;
      cmdPush  <= 1'b0;
      credits  <= CreditW'(`KNIGHT_QUEUE_DEPTH);
    end else begin
      cmdPush <= spend;
      if (byteValid) begin
        haveHigh <= !haveHigh;
      end
      // Each pop of the queue hands one credit back
      credits <= credits + CreditW'(cmdCreditReturn) - CreditW'(spend);
    end
  end

  // The high byte comes first and waits here for its partner
  always_ff @(posedge clk) begin
    if (byteValid && !haveHigh) begin
      highByte <= byteData;
    end
    if (spend) begin
      cmdWord <= {highByte, byteData};
    end
  end

endmodule

//--- uart/uartTx.sv
`timescale 1ns/1ps
`include "knight_config.svh"

// UART transmitter for response bytes, 8N1, LSB first
module uartTx (
  input  logic                clk,
  input  logic                rst,
  input  logic                respValid,
  input  knightPkg::respByte_t respHead,
  output logic                respPop,
  output logic                respCreditReturn,
  output logic                tx
);

  localparam logic [15:0] BaudLast = 16'(`KNIGHT_BAUD_DIV - 1);

  typedef enum logic {IDLE, SEND} txState_t;

  txState_t    state;
  logic [15:0] baudCnt;
  logic [3:0]  bitCnt;
  logic [8:0]  shiftReg;
  logic        take;

  // A byte is taken from the queue only while the line is idle
  // Taking it frees a queue entry, so a credit goes back to the sequencer
  assign take             = (state == IDLE) && respValid;
  assign respPop          = take;
  assign respCreditReturn = take;

  ////////////////////////////////////////////////////////////
  // Serializer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= IDLE;
      baudCnt <= '0;
      bitCnt  <= '0;
      tx      <= 1'b1;
    end else begin
      case (state)
        IDLE: begin
          if (take) begin
            // The start bit goes out at once
            tx      <= 1'b0;
            baudCnt <= '0;
            bitCnt  <= '0;
            state   <= SEND;
          end
        end
        SEND: begin
          if (baudCnt == BaudLast) begin
            baudCnt <= '0;
            // bitCnt counts finished bits, the stop bit is the ninth after the start
            if (bitCnt == 4'd9) begin
              state <= IDLE;
            end else begin
              tx     <= shiftReg[0];
              bitCnt <= bitCnt + 4'd1;
            end
          end else begin
            baudCnt <= baudCnt + 16'd1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Data with the stop bit above it, ones fill in behind as it shifts
  always_ff @(posedge clk) begin
    if (take) begin
      shiftReg <= {1'b1, respHead};
    end else if (state == SEND && baudCnt == BaudLast) begin
      shiftReg <= {1'b1, shiftReg[8:1]};
    end
  end

endmodule

//--- uart/uartRx.sv
`timescale 1ns/1ps
`include "knight_config.svh"

// UART receiver for 8N1 frames, LSB first, idle high
module uartRx (
  input  logic       clk,
  input  logic       rst,
  input  logic       rx,
  output logic       byteValid,
  output logic [7:0] byteData
);

  // Last count of a full bit and of half a bit
  localparam logic [15:0] BaudLast = 16'(`KNIGHT_BAUD_DIV - 1);
  localparam logic [15:0] BaudHalf = 16'(`KNIGHT_BAUD_DIV / 2 - 1);

  typedef enum logic [1:0] {IDLE, START, DATA, STOP} rxState_t;

  rxState_t    state;
  logic        rxMeta;
  logic        rxSync;
  logic [15:0] baudCnt;
  logic [2:0]  bitCnt;
  logic [7:0]  shiftReg;

  // Two flops bring the serial line into the clock domain
  // They come up high so a reset does not look like a start bit
  always_ff @(posedge clk) begin
    if (rst) begin
      rxMeta <= 1'b1;
      rxSync <= 1'b1;
    end else begin
      rxMeta <= rx;
      rxSync <= rxMeta;
    end
  end

  ////////////////////////////////////////////////////////////
  // Frame state machine
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= IDLE;
      baudCnt   <= '0;
      bitCnt    <= '0;
      byteValid <= 1'b0;
    end else begin
      byteValid <= 1'b0;
      case (state)
        IDLE: begin
          // A low level on the line marks the leading edge of a start bit
          if (!rxSync) begin
            state   <= START;
            baudCnt <= '0;
          end
        end
        START: begin
          // Check the start bit again at its middle, a short glitch goes back to idle
          if (baudCnt == BaudHalf) begin
            baudCnt <= '0;
            bitCnt  <= '0;
            state   <= rxSync ? IDLE : DATA;
          end else begin
            baudCnt <= baudCnt + 16'd1;
          end
        end
        DATA: begin
          // From here on every sample falls in the middle of a bit
          if (baudCnt == BaudLast) begin
            baudCnt <= '0;
            if (bitCnt == 3'd7) begin
              state <= STOP;
            end
            bitCnt <= bitCnt + 3'd1;
          end else begin
            baudCnt <= baudCnt + 16'd1;
          end
        end
        STOP: begin
          // A frame whose stop bit reads low is thrown away
          if (baudCnt == BaudLast) begin
            baudCnt   <= '0;
            state     <= IDLE;
            byteValid <= rxSync;
          end else begin
            baudCnt <= baudCnt + 16'd1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Data bits shift in from the top since the LSB arrives first
  always_ff @(posedge clk) begin
    if (state == DATA && baudCnt == BaudLast) begin
      shiftReg <= {rxSync, shiftReg[7:1]};
    end
  end

  assign byteData = shiftReg;

endmodule

//--- common/knightPkg.sv
package knightPkg;

  ////////////////////////////////////////////////////////////
  // Host link payloads
  ////////////////////////////////////////////////////////////

  // One host command that travels over the UART as two bytes with the high byte first
  typedef logic [15:0] cmdWord_t;

  // One response byte going back to the host
  typedef logic [7:0] respByte_t;

  // Command field in bits 15..12 of a command word
  // Codes not listed here are answered with a NAK
  typedef enum logic [3:0] {
    STOP  = 4'd2,
    DRIVE = 4'd4
  } opcode_t;

  ////////////////////////////////////////////////////////////
  // Motor levels
  ////////////////////////////////////////////////////////////

  // Duty level out of 64 that serves both as target and as ramped level
  typedef logic [5:0] level_t;

  // Sent once every motor has settled after DRIVE or STOP
  localparam respByte_t RESP_ACK = 8'hA5;

  // Sent right away for an opcode the core does not know
  localparam respByte_t RESP_NAK = 8'hE0;

endpackage

//--- common/knight_config.svh
`ifndef KNIGHT_CONFIG_SVH
`define KNIGHT_CONFIG_SVH

// Clock cycles per UART bit, kept short for simulation
`define KNIGHT_BAUD_DIV 8

// Clock cycles between two single-step changes of a motor level
`define KNIGHT_RAMP_DIV 64

// Entries per queue, which is also the number of credits a producer starts with
// Must be a power of two
`define KNIGHT_QUEUE_DEPTH 4

// Number of motor drives in the generate loop
`define KNIGHT_NUM_MOTORS 2

`endif
